// File: rtl/fsb_dma_settings.svh
// fixed 80-bit fsb into 512-bit axi beats; beats are whole, so ring base and size are 64-byte aligned
`ifndef FSB_DMA_SETTINGS_SVH
`define FSB_DMA_SETTINGS_SVH

`define FSB_WIDTH       80
`define SLOT_WIDTH      128
`define SLOTS_PER_BEAT  4
`define BEAT_WIDTH      512
`define BEAT_BYTES      64
`define AXI_ADDR_WIDTH  64
`define CFG_ADDR_WIDTH  8
`define CFG_DATA_WIDTH  32
`define FIFO_DEPTH      2

// configuration register map, byte offsets
`define REG_CTRL        8'h00
`define REG_GO          8'h08
`define REG_BASE_LO     8'h20
`define REG_BASE_HI     8'h24
`define REG_READ_HEAD   8'h28
`define REG_BURST       8'h2c
`define REG_RING_SIZE   8'h30

`endif

// File: rtl/fsb_dma_pkg.sv
// burst word is decoded only by the writer; adjust and user fields are stored for readback
`include "fsb_dma_settings.svh"

package fsb_dma_pkg;

  // burst register, raw view for storage, field view for decode
  typedef union packed {
    logic [`CFG_DATA_WIDTH-1:0] raw;
    struct packed {
      // free for host software
      logic [15:0] user;
      // readback only
      logic [7:0]  adjust;
      // beats per burst minus one
      logic [7:0]  burst_len;
    } f;
  } cfg_word_u;

  // ring writer states
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_ADDR = 2'd1,
    WR_DATA = 2'd2,
    WR_STOP = 2'd3
  } wr_state_t;

endpackage

// File: rtl/ring_cfg_if.sv
// go and stop are single-cycle pulses; ring settings hold steady while the writer is busy
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

interface ring_cfg_if
  import fsb_dma_pkg::*;
();

  // ring setup from the register block
  logic [`AXI_ADDR_WIDTH-1:0] base;
  logic [`CFG_DATA_WIDTH-1:0] ring_size;
  logic [`CFG_DATA_WIDTH-1:0] read_head;
  cfg_word_u                  burst;
  logic                       go;
  logic                       stop;

  // status back from the writer
  logic                       busy;
  logic                       stop_pend;
  logic [1:0]                 last_bresp;

  modport regs (
    output base, ring_size, read_head, burst, go, stop,
    input  busy, stop_pend, last_bresp
  );

  modport writer (
    input  base, ring_size, read_head, burst, go, stop,
    output busy, stop_pend, last_bresp
  );

endinterface

// File: rtl/cfg_regs.sv
// ack comes two cycles after the strobe; the host must wait for ack before the next access
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

module cfg_regs
  import fsb_dma_pkg::*;
(
  input  logic                       clk,
  input  logic                       sync_rst_n,
  input  logic                       cfg_wr_i,
  input  logic                       cfg_rd_i,
  input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i,
  output logic                       cfg_ack_o,
  output logic [`CFG_DATA_WIDTH-1:0] cfg_rdata_o,
  output logic                       fsb_enable_o,
  ring_cfg_if.regs                   ring
);

  logic                       wr_q;
  logic                       rd_q;
  logic [`CFG_ADDR_WIDTH-1:0] addr_q;
  logic [`CFG_DATA_WIDTH-1:0] wdata_q;
  logic                       access_end;
  logic                       go_wr;
  logic [`AXI_ADDR_WIDTH-1:0] base_q;
  logic [`CFG_DATA_WIDTH-1:0] head_q;
  logic [`CFG_DATA_WIDTH-1:0] size_q;
  cfg_word_u                  burst_q;

  // ----------------------------------------------------------------------
  // access capture and stretched ack
  // ----------------------------------------------------------------------
  // high on the cycle before ack, i.e. strobe + 1
  assign access_end = (wr_q || rd_q) && !cfg_ack_o;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
      cfg_ack_o <= 1'b0;
    end
    else
    begin
      // held until the ack cycle
      wr_q      <= cfg_wr_i || (wr_q && !cfg_ack_o);
      rd_q      <= cfg_rd_i || (rd_q && !cfg_ack_o);
      cfg_ack_o <= access_end;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cfg_wr_i || cfg_rd_i)
    begin
      addr_q  <= cfg_addr_i;
      wdata_q <= cfg_wdata_i;
    end
  end

  // ----------------------------------------------------------------------
  // register store, visible from the ack cycle on
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      fsb_enable_o <= 1'b0;
      base_q       <= '0;
      head_q       <= '0;
      size_q       <= '0;
      burst_q.raw  <= '0;
    end
    else if (wr_q && access_end)
    begin
      case (addr_q)
        `REG_CTRL:      fsb_enable_o <= wdata_q[0];
        `REG_BASE_LO:   base_q[31:0] <= wdata_q;
        `REG_BASE_HI:   base_q[63:32] <= wdata_q;
        `REG_READ_HEAD: head_q <= wdata_q;
        `REG_BURST:     burst_q.raw <= wdata_q;
        `REG_RING_SIZE: size_q <= wdata_q;
        default:        ;
      endcase
    end
  end

  assign ring.base      = base_q;
  assign ring.read_head = head_q;
  assign ring.ring_size = size_q;
  assign ring.burst     = burst_q;

  // go/stop pulse on the ack cycle of a REG_GO write
  assign go_wr     = wr_q && cfg_ack_o && (addr_q == `REG_GO);
  assign ring.go   = go_wr && wdata_q[0];
  assign ring.stop = go_wr && !wdata_q[0];

  // readback word lands together with ack
  always_ff @(posedge clk)
  begin
    if (access_end)
    begin
      case (addr_q)
        `REG_CTRL:      cfg_rdata_o <= {{(`CFG_DATA_WIDTH-1){1'b0}}, fsb_enable_o};
        `REG_GO:        cfg_rdata_o <= {{(`CFG_DATA_WIDTH-4){1'b0}}, ring.last_bresp,
                                        ring.stop_pend, ring.busy};
        `REG_BASE_LO:   cfg_rdata_o <= base_q[31:0];
        `REG_BASE_HI:   cfg_rdata_o <= base_q[63:32];
        `REG_READ_HEAD: cfg_rdata_o <= head_q;
        `REG_BURST:     cfg_rdata_o <= burst_q.raw;
        `REG_RING_SIZE: cfg_rdata_o <= size_q;
        // unmapped
        default:        cfg_rdata_o <= '1;
      endcase
    end
  end

endmodule

// File: rtl/fsb_packer.sv
// one fsb packet per 128-bit slot, slot 0 in the low bits; no packet is taken while a beat waits
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

module fsb_packer (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic                   fsb_enable_i,
  input  logic                   fsb_valid_i,
  input  logic [`FSB_WIDTH-1:0]  fsb_data_i,
  output logic                   fsb_yumi_o,
  output logic                   beat_valid_o,
  input  logic                   beat_ready_i,
  output logic [`BEAT_WIDTH-1:0] beat_data_o
);

  localparam int SLOT_BITS = $clog2(`SLOTS_PER_BEAT);

  logic [SLOT_BITS-1:0] slot_cnt;

  // take the packet this cycle, beat register must be free
  assign fsb_yumi_o = fsb_valid_i && fsb_enable_i && !beat_valid_o;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      slot_cnt     <= '0;
      beat_valid_o <= 1'b0;
    end
    else
    begin
      // wraps back to slot 0 after the last slot
      if (fsb_yumi_o)
        slot_cnt <= slot_cnt + 1'b1;
      if (fsb_yumi_o && (slot_cnt == SLOT_BITS'(`SLOTS_PER_BEAT - 1)))
        beat_valid_o <= 1'b1;
      else if (beat_valid_o && beat_ready_i)
        beat_valid_o <= 1'b0;
    end
  end

  // zero-extend into the current slot
  always_ff @(posedge clk)
  begin
    if (fsb_yumi_o)
      beat_data_o[slot_cnt*`SLOT_WIDTH +: `SLOT_WIDTH] <=
        {{(`SLOT_WIDTH-`FSB_WIDTH){1'b0}}, fsb_data_i};
  end

  // pending beat parks the slot counter at slot 0
  a_slot_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    beat_valid_o |-> (slot_cnt == '0));

endmodule

// File: rtl/beat_fifo.sv
// entry shows at the output one cycle after push; push ready drops when full
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

module beat_fifo #(
  parameter int WIDTH = `BEAT_WIDTH,
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic             clk,
  input  logic             sync_rst_n,
  input  logic             push_valid_i,
  output logic             push_ready_o,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             pop_valid_o,
  input  logic             pop_ready_i,
  output logic [WIDTH-1:0] pop_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign push_ready_o = (count != CNT_W'(DEPTH));
  assign pop_valid_o  = (count != '0);
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;
  assign pop_data_o   = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data_i;
  end

  // ----------------------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // waiting head entry never overwritten by a push
  a_no_push_full: assert property (@(posedge clk) disable iff (!sync_rst_n)
    pop_valid_o && !pop_ready_i |=> $stable(pop_data_o));
  // empty fifo keeps both pointers together
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

// File: rtl/ring_writer.sv
// burst length and ring size must hold while busy; ring size is a multiple of the burst bytes
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

module ring_writer
  import fsb_dma_pkg::*;
(
  input  logic                       clk,
  input  logic                       sync_rst_n,
  ring_cfg_if.writer                 ring,
  input  logic                       beat_valid_i,
  output logic                       beat_ready_o,
  input  logic [`BEAT_WIDTH-1:0]     beat_data_i,
  output logic                       awvalid_o,
  input  logic                       awready_i,
  output logic [`AXI_ADDR_WIDTH-1:0] awaddr_o,
  output logic [7:0]                 awlen_o,
  output logic                       wvalid_o,
  input  logic                       wready_i,
  output logic [`BEAT_WIDTH-1:0]     wdata_o,
  output logic                       wlast_o,
  input  logic                       bvalid_i,
  input  logic [1:0]                 bresp_i,
  output logic                       bready_o
);

  wr_state_t                  state;
  wr_state_t                  state_nxt;
  logic [`CFG_DATA_WIDTH-1:0] tail;
  logic [`CFG_DATA_WIDTH-1:0] tail_inc;
  logic [`CFG_DATA_WIDTH-1:0] tail_nxt;
  logic [`CFG_DATA_WIDTH-1:0] burst_bytes;
  logic [7:0]                 beat_cnt;
  logic [3:0]                 out_cnt;
  logic                       stop_q;
  logic                       room;
  logic                       aw_fire;
  logic                       burst_done;

  // ----------------------------------------------------------------------
  // ring arithmetic
  // ----------------------------------------------------------------------
  assign burst_bytes = ({24'd0, ring.burst.f.burst_len} + 32'd1) * `BEAT_BYTES;
  assign tail_inc    = tail + burst_bytes;
  assign tail_nxt    = (tail_inc >= ring.ring_size) ? '0 : tail_inc;
  // full when the next tail would land on the host read head
  assign room        = (tail_nxt != ring.read_head);

  assign aw_fire    = awvalid_o && awready_i;
  assign burst_done = wvalid_o && wready_i && wlast_o;

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      WR_IDLE: if (ring.go) state_nxt = WR_ADDR;
      // stop while stalled on a full ring ends here
      WR_ADDR:
      begin
        if (aw_fire)
          state_nxt = WR_DATA;
        else if (stop_q && !awvalid_o)
          state_nxt = WR_STOP;
      end
      WR_DATA: if (burst_done) state_nxt = stop_q ? WR_STOP : WR_ADDR;
      // drain outstanding write responses
      WR_STOP: if (out_cnt == '0) state_nxt = WR_IDLE;
      default: state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      state      <= WR_IDLE;
      tail       <= '0;
      awvalid_o  <= 1'b0;
      stop_q     <= 1'b0;
      out_cnt    <= '0;
      ring.last_bresp <= 2'b00;
    end
    else
    begin
      state  <= state_nxt;
      stop_q <= (ring.stop && ring.busy) || (stop_q && (state_nxt != WR_IDLE));
      // fresh start at offset 0
      if (state == WR_IDLE)
        tail <= '0;
      else if (burst_done)
        tail <= tail_nxt;
      if (aw_fire)
        awvalid_o <= 1'b0;
      else if ((state == WR_ADDR) && room && !stop_q)
        awvalid_o <= 1'b1;
      case ({burst_done, bvalid_i})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: ;
      endcase
      if (bvalid_i)
        ring.last_bresp <= bresp_i;
    end
  end

  // address frozen once awvalid is up
  always_ff @(posedge clk)
  begin
    if ((state == WR_ADDR) && !awvalid_o)
    begin
      awaddr_o <= ring.base + {32'd0, tail};
      awlen_o  <= ring.burst.f.burst_len;
    end
  end

  // beats left in the burst, 0 marks wlast
  always_ff @(posedge clk)
  begin
    if (aw_fire)
      beat_cnt <= awlen_o;
    else if (wvalid_o && wready_i)
      beat_cnt <= beat_cnt - 1'b1;
  end

  assign wvalid_o       = (state == WR_DATA) && beat_valid_i;
  assign beat_ready_o   = (state == WR_DATA) && wready_i;
  assign wdata_o        = beat_data_i;
  assign wlast_o        = (state == WR_DATA) && (beat_cnt == 8'd0);
  assign bready_o       = 1'b1;
  assign ring.busy      = (state != WR_IDLE);
  assign ring.stop_pend = stop_q;

  a_aw_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awlen_o));

endmodule

// File: rtl/fsb_dma_top.sv
// fsb to axi4 write dma; bready is tied high and every beat is written with all strobes set
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

module fsb_dma_top (
  input  logic                       clk,
  input  logic                       sync_rst_n,
  // configuration bus
  input  logic                       cfg_wr_i,
  input  logic                       cfg_rd_i,
  input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i,
  output logic                       cfg_ack_o,
  output logic [`CFG_DATA_WIDTH-1:0] cfg_rdata_o,
  // fsb
  input  logic                       fsb_valid_i,
  input  logic [`FSB_WIDTH-1:0]      fsb_data_i,
  output logic                       fsb_yumi_o,
  // axi aw, w, b
  output logic                       awvalid_o,
  input  logic                       awready_i,
  output logic [`AXI_ADDR_WIDTH-1:0] awaddr_o,
  output logic [7:0]                 awlen_o,
  output logic                       wvalid_o,
  input  logic                       wready_i,
  output logic [`BEAT_WIDTH-1:0]     wdata_o,
  output logic                       wlast_o,
  input  logic                       bvalid_i,
  input  logic [1:0]                 bresp_i,
  output logic                       bready_o
);

  logic                   fsb_enable;
  logic                   push_valid;
  logic                   push_ready;
  logic [`BEAT_WIDTH-1:0] push_data;
  logic                   pop_valid;
  logic                   pop_ready;
  logic [`BEAT_WIDTH-1:0] pop_data;

  ring_cfg_if ring_if ();

  cfg_regs regs_i (
    .clk, .sync_rst_n, .cfg_wr_i, .cfg_rd_i, .cfg_addr_i, .cfg_wdata_i,
    .cfg_ack_o, .cfg_rdata_o, .fsb_enable_o(fsb_enable), .ring(ring_if.regs)
  );

  fsb_packer packer_i (
    .clk, .sync_rst_n, .fsb_enable_i(fsb_enable), .fsb_valid_i, .fsb_data_i, .fsb_yumi_o,
    .beat_valid_o(push_valid), .beat_ready_i(push_ready), .beat_data_o(push_data)
  );

  beat_fifo fifo_i (
    .clk, .sync_rst_n, .push_valid_i(push_valid), .push_ready_o(push_ready),
    .push_data_i(push_data), .pop_valid_o(pop_valid), .pop_ready_i(pop_ready),
    .pop_data_o(pop_data)
  );

  ring_writer writer_i (
    .clk, .sync_rst_n, .ring(ring_if.writer),
    .beat_valid_i(pop_valid), .beat_ready_o(pop_ready), .beat_data_i(pop_data),
    .awvalid_o, .awready_i, .awaddr_o, .awlen_o,
    .wvalid_o, .wready_i, .wdata_o, .wlast_o,
    .bvalid_i, .bresp_i, .bready_o
  );

endmodule

// File: sim/tb_fsb_dma.sv
// run from the project root; ring size must be a multiple of the burst bytes in the test data
`timescale 1ns/1ps
`include "fsb_dma_settings.svh"

module tb_fsb_dma;

  localparam int TIMEOUT = 3000;

  logic                       clk = 1'b0;
  logic                       sync_rst_n;
  logic                       cfg_wr_i;
  logic                       cfg_rd_i;
  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i;
  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i;
  logic                       cfg_ack_o;
  logic [`CFG_DATA_WIDTH-1:0] cfg_rdata_o;
  logic                       fsb_valid_i = 1'b0;
  logic [`FSB_WIDTH-1:0]      fsb_data_i = '0;
  logic                       fsb_yumi_o;
  logic                       awvalid_o;
  logic                       awready_i = 1'b0;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr_o;
  logic [7:0]                 awlen_o;
  logic                       wvalid_o;
  logic                       wready_i = 1'b0;
  logic [`BEAT_WIDTH-1:0]     wdata_o;
  logic                       wlast_o;
  logic                       bvalid_i = 1'b0;
  logic [1:0]                 bresp_i = 2'b00;
  logic                       bready_o;

  // test data and ring model
  logic [`FSB_WIDTH-1:0]      tdata [0:11];
  logic [63:0]                ring_base;
  logic [31:0]                ring_size;
  logic [31:0]                head0;
  logic [31:0]                burst_bytes;
  logic [31:0]                model_tail = '0;
  logic [31:0]                mon_off = '0;
  logic [7:0]                 blen;
  logic [31:0]                rng = 32'd18;
  logic                       feed_en = 1'b0;
  int                         sent = 0;
  int                         aw_seen = 0;
  int                         aw_target = 0;
  int                         beats_seen = 0;
  int                         bursts_done = 0;
  int                         b_sent = 0;

  fsb_dma_top dut_i (.*);

  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // file packets reused in order, index tag keeps every packet unique
  function automatic logic [`FSB_WIDTH-1:0] make_pkt(input int k);
    return tdata[4 + (k % 8)] ^ {k[7:0], 72'h0};
  endfunction

  // four packets per beat, slot 0 lowest, upper slot bits zero
  function automatic logic [`BEAT_WIDTH-1:0] expected_beat(input int b);
    logic [`BEAT_WIDTH-1:0] e;
    e = '0;
    for (int i = 0; i < `SLOTS_PER_BEAT; i++)
      e[i*`SLOT_WIDTH +: `FSB_WIDTH] = make_pkt(`SLOTS_PER_BEAT*b + i);
    return e;
  endfunction

  function automatic logic [31:0] ring_next(input logic [31:0] off);
    return (off + burst_bytes >= ring_size) ? 32'd0 : off + burst_bytes;
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check(input logic [511:0] got, input logic [511:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  // one host access, ack expected two cycles after the strobe
  task automatic cfg_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 1;
    @(posedge clk);
    cfg_wr_i    <= wr;
    cfg_rd_i    <= !wr;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= wdata;
    @(posedge clk);
    cfg_wr_i <= 1'b0;
    cfg_rd_i <= 1'b0;
    @(negedge clk);
    while (!cfg_ack_o)
    begin
      if (n == 20)
      begin
        $display("timeout: no configuration ack for address %0h", addr);
        abort_run();
      end
      @(negedge clk);
      n++;
    end
    check(512'(n), 512'(2), "configuration ack latency");
    rdata = cfg_rdata_o;
  endtask

  // bursts the ring model allows before full, then a quiet window
  task automatic expect_bursts_to_full(input logic [31:0] head);
    int n;
    n = 0;
    while (ring_next(model_tail) != head && n < 64)
    begin
      model_tail = ring_next(model_tail);
      aw_target++;
      n++;
    end
    n = 0;
    while (aw_seen < aw_target || beats_seen < aw_target * (int'(blen) + 1))
    begin
      if (n == TIMEOUT)
      begin
        $display("timeout: expected %0d bursts, saw %0d bursts and %0d beats",
                 aw_target, aw_seen, beats_seen);
        abort_run();
      end
      @(negedge clk);
      n++;
    end
    repeat (40) @(negedge clk);
    check(512'(aw_seen), 512'(aw_target), "burst issued past the full point");
  endtask

  // ----------------------------------------------------------------------
  // fsb source, axi slave and monitor
  // ----------------------------------------------------------------------
  always @(posedge clk)
  begin : fsb_drive
    int nxt;
    nxt = sent + ((fsb_valid_i && fsb_yumi_o) ? 1 : 0);
    sent        <= nxt;
    fsb_valid_i <= feed_en;
    fsb_data_i  <= make_pkt(nxt);
  end

  // random ready, one OKAY response per finished burst
  always @(posedge clk)
  begin
    rng       <= xorshift(rng);
    awready_i <= rng[0];
    wready_i  <= rng[5] | rng[9];
    bresp_i   <= 2'b00;
    if (b_sent < bursts_done)
    begin
      bvalid_i <= 1'b1;
      b_sent   <= b_sent + 1;
    end
    else
      bvalid_i <= 1'b0;
  end

  // handshakes seen at the falling edge complete on the next rising edge
  always @(negedge clk)
  begin
    if (sync_rst_n && awvalid_o && awready_i)
    begin
      check(512'(awaddr_o), 512'(ring_base + {32'd0, mon_off}), "awaddr");
      check(512'(awlen_o), 512'(blen), "awlen");
      mon_off <= ring_next(mon_off);
      aw_seen <= aw_seen + 1;
    end
    if (sync_rst_n && wvalid_o && wready_i)
    begin
      check(wdata_o, expected_beat(beats_seen), "wdata");
      check(512'(wlast_o), 512'((beats_seen % (int'(blen) + 1)) == int'(blen)), "wlast");
      beats_seen <= beats_seen + 1;
      if (wlast_o)
        bursts_done <= bursts_done + 1;
    end
    if (sync_rst_n && bvalid_i)
      check(512'(bready_o), 512'(1), "bready during write response");
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    logic [31:0] rd;
    logic [7:0]  raddr [7];
    logic [31:0] rval [7];
    int          n;
    cfg_wr_i    = 1'b0;
    cfg_rd_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    sync_rst_n  = 1'b0;
    $readmemh("sim/fsb_dma_testdata.hex", tdata);
    ring_base   = tdata[0][63:0];
    ring_size   = tdata[1][31:0];
    blen        = tdata[2][7:0];
    head0       = tdata[3][31:0];
    burst_bytes = (32'(blen) + 32'd1) * `BEAT_BYTES;
    repeat (2) @(posedge clk);
    sync_rst_n <= 1'b1;
    @(negedge clk);
    check(512'({cfg_ack_o, fsb_yumi_o, awvalid_o, wvalid_o}), 512'(0), "outputs after reset");

    // register map, last entry unmapped
    raddr[0] = `REG_CTRL;
    rval[0]  = 32'd1;
    raddr[1] = `REG_BASE_LO;
    rval[1]  = ring_base[31:0];
    raddr[2] = `REG_BASE_HI;
    rval[2]  = ring_base[63:32];
    raddr[3] = `REG_READ_HEAD;
    rval[3]  = head0;
    raddr[4] = `REG_BURST;
    rval[4]  = {16'hc0de, 8'h5a, blen};
    raddr[5] = `REG_RING_SIZE;
    rval[5]  = ring_size;
    raddr[6] = 8'h3c;
    rval[6]  = 32'hffff_ffff;
    for (int i = 0; i < 6; i++)
      cfg_access(1'b1, raddr[i], rval[i], rd);
    for (int i = 0; i < 7; i++)
    begin
      cfg_access(1'b0, raddr[i], 32'd0, rd);
      check(512'(rd), 512'(rval[i]), "register readback");
    end
    cfg_access(1'b0, `REG_GO, 32'd0, rd);
    check(512'(rd), 512'(0), "status before go");

    // fsb masked, nothing taken
    cfg_access(1'b1, `REG_CTRL, 32'd0, rd);
    feed_en = 1'b1;
    repeat (10)
    begin
      @(negedge clk);
      check(512'(fsb_yumi_o), 512'(0), "yumi while fsb masked");
    end
    cfg_access(1'b1, `REG_CTRL, 32'd1, rd);
    cfg_access(1'b1, `REG_GO, 32'd1, rd);

    // fill, move the head back one burst, then wrap
    expect_bursts_to_full(head0);
    cfg_access(1'b1, `REG_READ_HEAD, head0 - burst_bytes, rd);
    expect_bursts_to_full(head0 - burst_bytes);
    cfg_access(1'b1, `REG_READ_HEAD, head0, rd);
    expect_bursts_to_full(head0);

    // soft stop while stalled
    cfg_access(1'b1, `REG_GO, 32'd0, rd);
    rd = '1;
    n  = 0;
    while (rd[0])
    begin
      if (n == 100)
      begin
        $display("timeout: writer still busy after stop");
        abort_run();
      end
      cfg_access(1'b0, `REG_GO, 32'd0, rd);
      n++;
    end
    check(512'(rd[3:0]), 512'(0), "status after stop");
    check(512'(aw_seen), 512'(aw_target), "bursts after stop");
    check(512'(b_sent), 512'(aw_seen), "write responses");
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/fsb_dma_pkg.sv
rtl/ring_cfg_if.sv
rtl/cfg_regs.sv
rtl/fsb_packer.sv
rtl/beat_fifo.sv
rtl/ring_writer.sv
rtl/fsb_dma_top.sv
sim/tb_fsb_dma.sv

// File: Makefile
# Verilator build for the FSB to AXI4 write DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_fsb_dma
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/fsb_dma_settings.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/fsb_dma_testdata.hex
// word 0 ring base, word 1 ring size in bytes, word 2 burst length minus one, word 3 read head
// words 4 to 11 are 80-bit fsb packets, reused in order with the packet index in the top byte
0000000200001000
00000180
00000001
00000100
0123456789abcdef0011
fedcba98765432100022
a5a5a5a55a5a5a5a0033
00000000000000000044
ffffffffffffffffff55
13579bdf2468ace00066
80000000000000000077
deadbeefcafef00d0088
